//--- list.f
ssm_cfg_pkg.sv
ssm_ctrl_pkg.sv
ssm_ctrl.sv
ssm_scalar_stage.sv
ssm_state_update.sv
ssm_output_reduce.sv
ssm_block_top.sv
tb_ssm_block.sv

//--- Bender.yml
package:
  name: ssm_block

sources:
  - ssm_cfg_pkg.sv
  - ssm_ctrl_pkg.sv
  - ssm_ctrl.sv
  - ssm_scalar_stage.sv
  - ssm_state_update.sv
  - ssm_output_reduce.sv
  - ssm_block_top.sv
  - target: test
    files:
      - tb_ssm_block.sv

//--- tb_ssm_block.sv
// ssm block testbench
`timescale 1ns/1ps
`default_nettype none

module tb_ssm_block;

    localparam int TPG         = ssm_cfg_pkg::TILES_PER_GROUP;
    localparam int LAT         = ssm_ctrl_pkg::LAT_PIPE;   // sample edge to y edge
    localparam int RST_CYCLES  = 10;
    localparam int MAX_GAP     = 3;                 // most idle cycles between tiles in test 4
    localparam int N_GROUPS    = 1 + 1 + 20 + 10 + 1 + 2;
    localparam int DRAIN_MAX   = 2 * LAT;           // wait for outstanding pulses
    localparam int IDLE_CYCLES = 20 + 10 + 10 * TPG * MAX_GAP + DRAIN_MAX + 2;
    localparam int CYCLE_LIMIT = RST_CYCLES + N_GROUPS * TPG + IDLE_CYCLES
                               + 6 * (DRAIN_MAX + 3) + 20;

    logic clk = 1'b0;
    logic rstn, tile_valid_i, y_final_valid_o;
    ssm_cfg_pkg::lane_t     dt_i, dt_bias_i, x_i, d_i, a_decay_i, y_final_o;
    ssm_cfg_pkg::tile_vec_t b_tile_i, c_tile_i, hprev_tile_i;

    logic [31:0]        rng_state = 32'hbf2b;
    int                 cyc, err_cnt, chk_cnt, pulse_cnt, test_no, err_mark, pulse_mark;
    ssm_cfg_pkg::lane_t exp_y_q[$];             // model results, oldest first
    int                 exp_cyc_q[$];           // cycle each pulse is due
    ssm_cfg_pkg::lane_t got_y_q[$];             // observed y, for test 6
    int                 mdl_idx;                // tile position inside the group
    ssm_cfg_pkg::lane_t mdl_acc;                // running group sum of the model
    ssm_cfg_pkg::lane_t want_y;
    int                 want_cyc;

    ssm_block_top u_dut (
        .clk (clk), .rstn (rstn), .tile_valid_i (tile_valid_i),
        .dt_i (dt_i), .dt_bias_i (dt_bias_i), .x_i (x_i), .d_i (d_i),
        .a_decay_i (a_decay_i), .b_tile_i (b_tile_i), .c_tile_i (c_tile_i),
        .hprev_tile_i (hprev_tile_i), .y_final_o (y_final_o),
        .y_final_valid_o (y_final_valid_o)
    );

    always #2 clk = ~clk;                       // 4 ns period
    always @(posedge clk) cyc <= cyc + 1;       // edges seen so far

    // ========================================
    // stimulus helpers and reference model
    // ========================================
    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // roughly -2.0 .. +2.0 in q8.8
    function automatic ssm_cfg_pkg::lane_t small_q88();
        logic [31:0] r;
        r = xorshift32();
        return {{6{r[9]}}, r[9:0]};
    endfunction

    // q8.8 product, arithmetic shift, low 16 bits kept
    function automatic ssm_cfg_pkg::lane_t mul_q88(input ssm_cfg_pkg::lane_t a,
                                                   input ssm_cfg_pkg::lane_t b);
        logic signed [31:0] p;
        p = a * b;
        p = p >>> ssm_cfg_pkg::FRAC_W;
        return p[15:0];
    endfunction

    task automatic model_tile(input ssm_cfg_pkg::lane_t dt, bias, x, d, decay,
                              input ssm_cfg_pkg::tile_vec_t h, b, c);
        ssm_cfg_pkg::lane_t delta, dx, hn, tsum;
        delta = dt + bias;                      // wraps at 16 bits
        dx    = mul_q88(delta, x);
        tsum  = '0;
        for (int l = 0; l < ssm_cfg_pkg::N_TILE; l++) begin
            hn   = mul_q88(decay, h[l]) + mul_q88(dx, b[l]);
            tsum = tsum + mul_q88(hn, c[l]);
        end
        // only the group's first tile brings x*D in
        mdl_acc = (mdl_idx == 0) ? tsum + mul_q88(x, d) : mdl_acc + tsum;
        if (mdl_idx == TPG - 1) begin
            exp_y_q.push_back(mdl_acc);
            exp_cyc_q.push_back(cyc + 1 + LAT);     // tile is sampled on the next edge
            mdl_idx = 0;
        end else begin
            mdl_idx++;
        end
    endtask

    task automatic drive_data();
        dt_i      = small_q88();
        dt_bias_i = small_q88();
        a_decay_i = small_q88();
        for (int l = 0; l < ssm_cfg_pkg::N_TILE; l++) begin
            b_tile_i[l]     = small_q88();
            c_tile_i[l]     = small_q88();
            hprev_tile_i[l] = small_q88();
        end
    endtask

    task automatic send_tile(input ssm_cfg_pkg::lane_t x_val, input ssm_cfg_pkg::lane_t d_val);
        @(negedge clk);
        drive_data();
        x_i          = x_val;
        d_i          = d_val;
        tile_valid_i = 1'b1;
        model_tile(dt_i, dt_bias_i, x_i, d_i, a_decay_i, hprev_tile_i, b_tile_i, c_tile_i);
    endtask

    // gap cycle with junk on the data inputs
    task automatic idle_cycle();
        @(negedge clk);
        drive_data();
        x_i          = small_q88();
        d_i          = small_q88();
        tile_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_y_q.size() != 0 && n < DRAIN_MAX) begin
            idle_cycle();
            n++;
        end
        if (exp_y_q.size() != 0) begin
            $display("%0t: %0d group results never showed up on y_final_valid_o",
                     $time, exp_y_q.size());
            err_cnt++;
            exp_y_q.delete();
            exp_cyc_q.delete();
        end
        repeat (2) idle_cycle();                // room for a stray pulse
    endtask

    task automatic end_test(input string name, input int groups);
        chk_cnt++;
        if (pulse_cnt - pulse_mark != groups) begin
            $display("%0t: test %s gave %0d pulses for %0d groups",
                     $time, name, pulse_cnt - pulse_mark, groups);
            err_cnt++;
        end
        test_no++;
        $display("test %0d %s groups %0d errors %0d",
                 test_no, name, groups, err_cnt - err_mark);
        err_mark   = err_cnt;
        pulse_mark = pulse_cnt;
    endtask

    // ========================================
    // output monitor sampled at the falling edge
    // ========================================
    always @(negedge clk) begin
        if (y_final_valid_o) begin
            pulse_cnt++;
            got_y_q.push_back(y_final_o);
            if (exp_y_q.size() == 0) begin
                $display("%0t: y_final_valid_o pulsed with no group outstanding", $time);
                err_cnt++;
            end else begin
                want_y   = exp_y_q.pop_front();
                want_cyc = exp_cyc_q.pop_front();
                chk_cnt  = chk_cnt + 2;
                if (y_final_o !== want_y) begin
                    $display("FAIL t=%0t y_final_o got %0d expected %0d",
                             $time, y_final_o, want_y);
                    err_cnt++;
                end
                if (cyc != want_cyc) begin
                    $display("FAIL t=%0t y_final_valid_o cycle got %0d expected %0d",
                             $time, cyc, want_cyc);
                    err_cnt++;
                end
            end
        end
        if (cyc >= CYCLE_LIMIT) begin
            $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ========================================
    // test sequence
    // ========================================
    initial begin
        int                 k;
        logic [31:0]        seed_save;
        ssm_cfg_pkg::lane_t xs[TPG];
        ssm_cfg_pkg::lane_t ds[TPG];
        rstn         = 1'b0;
        tile_valid_i = 1'b0;
        dt_i         = '0;
        dt_bias_i    = '0;
        x_i          = '0;
        d_i          = '0;
        a_decay_i    = '0;
        b_tile_i     = '0;
        c_tile_i     = '0;
        hprev_tile_i = '0;
        repeat (RST_CYCLES) @(negedge clk);
        rstn = 1'b1;

        // a partial group right after reset must not pulse
        repeat (20) idle_cycle();
        repeat (TPG - 1) send_tile(small_q88(), small_q88());
        repeat (10) idle_cycle();
        send_tile(small_q88(), small_q88());
        wait_drain();
        end_test("reset_quiet", 1);

        repeat (TPG) send_tile(small_q88(), small_q88());
        wait_drain();
        end_test("single_group", 1);

        repeat (20 * TPG) send_tile(small_q88(), small_q88());    // many groups in flight
        wait_drain();
        end_test("back_to_back", 20);

        repeat (10 * TPG) begin
            send_tile(small_q88(), small_q88());
            repeat (xorshift32() % (MAX_GAP + 1)) idle_cycle();
        end
        wait_drain();
        end_test("random_gaps", 10);

        // pulse edge counted from the edge that samples the last tile
        repeat (TPG) send_tile(small_q88(), small_q88());
        idle_cycle();
        k = 0;
        while (!y_final_valid_o && k < DRAIN_MAX) begin
            idle_cycle();
            k++;
        end
        chk_cnt = chk_cnt + 2;
        if (k != LAT) begin
            $display("FAIL t=%0t y_final_valid_o delay got %0d expected %0d", $time, k, LAT);
            err_cnt++;
        end
        idle_cycle();
        if (y_final_valid_o) begin
            $display("%0t: y_final_valid_o stayed high for more than one cycle", $time);
            err_cnt++;
        end
        wait_drain();
        end_test("pulse_timing", 1);

        // same group twice with D changed after the first tile only
        for (int i = 0; i < TPG; i++) begin
            xs[i] = small_q88();                // x changes on every tile
            ds[i] = small_q88();
        end
        seed_save = rng_state;
        for (int i = 0; i < TPG; i++) begin
            send_tile(xs[i], ds[i]);
        end
        rng_state = seed_save;                  // replay the other inputs
        for (int i = 0; i < TPG; i++) begin
            send_tile(xs[i], (i == 0) ? ds[i] : ds[i] + 16'sh0100);
        end
        wait_drain();
        chk_cnt++;
        if (got_y_q.size() < 2) begin
            $display("%0t: fewer than two results seen for the D test", $time);
            err_cnt++;
        end else if (got_y_q[$] !== got_y_q[$-1]) begin
            $display("FAIL t=%0t y_final_o got %0d expected %0d",
                     $time, got_y_q[$], got_y_q[$-1]);
            err_cnt++;
        end
        end_test("xd_first_only", 2);

        $display("%0d tests, %0d checks, %0d pulses, %0d errors",
                 test_no, chk_cnt, pulse_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ssm_block_top.sv
// ssm block top level
`timescale 1ns/1ps
`default_nettype none

module ssm_block_top (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          tile_valid_i,
    input  wire ssm_cfg_pkg::lane_t      dt_i,
    input  wire ssm_cfg_pkg::lane_t      dt_bias_i,
    input  wire ssm_cfg_pkg::lane_t      x_i,
    input  wire ssm_cfg_pkg::lane_t      d_i,
    input  wire ssm_cfg_pkg::lane_t      a_decay_i,
    input  wire ssm_cfg_pkg::tile_vec_t  b_tile_i,
    input  wire ssm_cfg_pkg::tile_vec_t  c_tile_i,
    input  wire ssm_cfg_pkg::tile_vec_t  hprev_tile_i,
    output ssm_cfg_pkg::lane_t           y_final_o,
    output logic                         y_final_valid_o
);

    // stage valids and group flags
    logic v_s1, v_s2, v_s3, v_s4, v_s5;
    logic first_s2, first_s5, last_s5;

    // datapath between stages
    ssm_cfg_pkg::lane_t     dx_w;
    ssm_cfg_pkg::lane_t     xd_w;
    ssm_cfg_pkg::tile_vec_t hnext_w;

    // ========================================
    // control
    // ========================================
    ssm_ctrl u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .tile_valid_i (tile_valid_i),
        .v_s1_o       (v_s1),
        .v_s2_o       (v_s2),
        .v_s3_o       (v_s3),
        .v_s4_o       (v_s4),
        .v_s5_o       (v_s5),
        .first_s2_o   (first_s2),
        .first_s5_o   (first_s5),
        .last_s5_o    (last_s5)
    );

    // ========================================
    // datapath
    // ========================================
    ssm_scalar_stage u_scalar (
        .clk        (clk),
        .rstn       (rstn),
        .v_s1_i     (v_s1),
        .first_s2_i (first_s2),
        .dt_i       (dt_i),
        .dt_bias_i  (dt_bias_i),
        .x_i        (x_i),
        .d_i        (d_i),
        .dx_o       (dx_w),
        .xd_o       (xd_w)
    );

    ssm_state_update u_state (
        .clk       (clk),
        .rstn      (rstn),
        .v_s2_i    (v_s2),
        .dx_i      (dx_w),
        .hprev_i   (hprev_tile_i),
        .b_i       (b_tile_i),
        .a_decay_i (a_decay_i),
        .hnext_o   (hnext_w)
    );

    ssm_output_reduce u_reduce (
        .clk        (clk),
        .rstn       (rstn),
        .v_s3_i     (v_s3),
        .v_s4_i     (v_s4),
        .v_s5_i     (v_s5),
        .first_s5_i (first_s5),
        .last_s5_i  (last_s5),
        .hnext_i    (hnext_w),
        .c_i        (c_tile_i),
        .xd_i       (xd_w),
        .y_o        (y_final_o),
        .y_valid_o  (y_final_valid_o)
    );

    // end to end: every y pulse comes from a tile sampled LAT_PIPE edges before
    a_y_latency: assert property (@(posedge clk) disable iff (!rstn)
        y_final_valid_o |-> $past(tile_valid_i, ssm_ctrl_pkg::LAT_PIPE + 1));

endmodule

`default_nettype wire

//--- ssm_output_reduce.sv
// ssm output reduction and group accumulation
`timescale 1ns/1ps
`default_nettype none

module ssm_output_reduce (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          v_s3_i,
    input  wire                          v_s4_i,
    input  wire                          v_s5_i,
    input  wire                          first_s5_i,  // tile opens a group
    input  wire                          last_s5_i,   // tile closes a group
    input  wire ssm_cfg_pkg::tile_vec_t  hnext_i,     // valid after stage 3
    input  wire ssm_cfg_pkg::tile_vec_t  c_i,         // valid on edge E
    input  wire ssm_cfg_pkg::lane_t      xd_i,        // valid after stage 2
    output ssm_cfg_pkg::lane_t           y_o,
    output logic                         y_valid_o
);

    ssm_cfg_pkg::tile_vec_t c_r0, c_r1, c_r2, c_r3;    // C delay line
    ssm_cfg_pkg::lane_t     xd_s3, xd_s4;               // xD riding with the tile
    ssm_cfg_pkg::lane_t     lane_sum;                   // comb sum over lanes
    ssm_cfg_pkg::lane_t     tile_sum_r;                 // stage 4
    ssm_cfg_pkg::lane_t     grp_sum_r;                  // running group sum
    ssm_cfg_pkg::lane_t     grp_next;

    // ========================================
    // alignment of C and xD
    // ========================================
    always_ff @(posedge clk) begin
        c_r0 <= c_i;
        c_r1 <= c_r0;
        c_r2 <= c_r1;
        if (v_s3_i) begin
            c_r3  <= c_r2;                      // meets hnext at stage 4
            xd_s3 <= xd_i;
        end
        if (v_s4_i) begin
            xd_s4 <= xd_s3;
        end
    end

    // ========================================
    // stage 4 lane sum of hnext * C
    // ========================================
    always_comb begin
        lane_sum = '0;
        for (int l = 0; l < ssm_cfg_pkg::N_TILE; l++) begin
            lane_sum = lane_sum + ssm_cfg_pkg::qmul(hnext_i[l], c_r3[l]);
        end
    end

    always_ff @(posedge clk) begin
        if (v_s4_i) begin
            tile_sum_r <= lane_sum;
        end
    end

    // ========================================
    // stage 5 group accumulation and y
    // ========================================
    // first tile restarts the sum and brings the group's xD in
    assign grp_next = first_s5_i ? tile_sum_r + xd_s4
                                 : grp_sum_r + tile_sum_r;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            grp_sum_r <= '0;
            y_o       <= '0;
            y_valid_o <= 1'b0;
        end else begin
            y_valid_o <= v_s5_i && last_s5_i;   // one pulse per group
            if (v_s5_i) begin
                grp_sum_r <= grp_next;
            end
            if (v_s5_i && last_s5_i) begin
                y_o <= grp_next;                // completed group value
            end
        end
    end

    // y is a single-cycle pulse right after the group's last tile
    a_y_after_last: assert property (@(posedge clk) disable iff (!rstn)
        y_valid_o |-> $past(last_s5_i) && !$past(y_valid_o));

endmodule

`default_nettype wire

//--- ssm_state_update.sv
// ssm state update per lane
`timescale 1ns/1ps
`default_nettype none

module ssm_state_update (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          v_s2_i,
    input  wire ssm_cfg_pkg::lane_t      dx_i,        // valid after stage 2
    input  wire ssm_cfg_pkg::tile_vec_t  hprev_i,     // valid on edge E
    input  wire ssm_cfg_pkg::tile_vec_t  b_i,
    input  wire ssm_cfg_pkg::lane_t      a_decay_i,
    output ssm_cfg_pkg::tile_vec_t       hnext_o
);

    ssm_cfg_pkg::tile_vec_t hprev_r0, hprev_r1, hprev_r2;
    ssm_cfg_pkg::tile_vec_t b_r0, b_r1, b_r2;
    ssm_cfg_pkg::lane_t     decay_r0, decay_r1, decay_r2;

    // ========================================
    // align hprev, B, decay with dx
    // ========================================
    always_ff @(posedge clk) begin
        hprev_r0 <= hprev_i;                    // edge E
        b_r0     <= b_i;
        decay_r0 <= a_decay_i;
        hprev_r1 <= hprev_r0;                   // E+1
        b_r1     <= b_r0;
        decay_r1 <= decay_r0;
        if (v_s2_i) begin                       // E+2, hold next to dx
            hprev_r2 <= hprev_r1;
            b_r2     <= b_r1;
            decay_r2 <= decay_r1;
        end
    end

    // ========================================
    // hnext = decay * hprev + dx * B
    // ========================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hnext_o <= '0;
        end else begin
            for (int l = 0; l < ssm_cfg_pkg::N_TILE; l++) begin
                hnext_o[l] <= ssm_cfg_pkg::qmul(decay_r2, hprev_r2[l])
                            + ssm_cfg_pkg::qmul(dx_i, b_r2[l]);   // wraps at 16b
            end
        end
    end

    // two edges after the stage-2 valid the new state must be clean
    a_hnext_known: assert property (@(posedge clk) disable iff (!rstn)
        $past(v_s2_i, 2) |-> !$isunknown(hnext_o));

endmodule

`default_nettype wire

//--- ssm_scalar_stage.sv
// ssm scalar stage, delta / dx / xD
`timescale 1ns/1ps
`default_nettype none

module ssm_scalar_stage (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire                       v_s1_i,
    input  wire                       first_s2_i,   // group-first tile at stage 2
    input  wire ssm_cfg_pkg::lane_t   dt_i,
    input  wire ssm_cfg_pkg::lane_t   dt_bias_i,
    input  wire ssm_cfg_pkg::lane_t   x_i,
    input  wire ssm_cfg_pkg::lane_t   d_i,
    output ssm_cfg_pkg::lane_t        dx_o,         // delta * x, per tile
    output ssm_cfg_pkg::lane_t        xd_o          // x * D, held per group
);

    ssm_cfg_pkg::lane_t dt_r;                   // input sample, edge E
    ssm_cfg_pkg::lane_t bias_r;
    ssm_cfg_pkg::lane_t x_r;
    ssm_cfg_pkg::lane_t d_r;
    ssm_cfg_pkg::lane_t delta_s1;               // stage 1
    ssm_cfg_pkg::lane_t x_s1;
    ssm_cfg_pkg::lane_t d_s1;

    // raw input capture, every cycle
    always_ff @(posedge clk) begin
        dt_r   <= dt_i;
        bias_r <= dt_bias_i;
        x_r    <= x_i;
        d_r    <= d_i;
    end

    // ========================================
    // stage 1: delta = dt + dt_bias
    // ========================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            delta_s1 <= '0;
            x_s1     <= '0;
            d_s1     <= '0;
        end else if (v_s1_i) begin
            delta_s1 <= dt_r + bias_r;          // 16b wrap
            x_s1     <= x_r;                    // carry x, D alongside delta
            d_s1     <= d_r;
        end
    end

    // ========================================
    // stage 2: dx and xD
    // ========================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dx_o <= '0;
            xd_o <= '0;
        end else begin
            dx_o <= ssm_cfg_pkg::qmul(delta_s1, x_s1);      // own x of every tile
            if (first_s2_i) begin
                xd_o <= ssm_cfg_pkg::qmul(x_s1, d_s1);      // only first tile counts
            end
        end
    end

endmodule

`default_nettype wire

//--- ssm_ctrl.sv
// ssm pipeline control
`timescale 1ns/1ps
`default_nettype none

module ssm_ctrl (
    input  wire  clk,
    input  wire  rstn,
    input  wire  tile_valid_i,                  // tile sampled on this edge
    output logic v_s1_o,
    output logic v_s2_o,
    output logic v_s3_o,
    output logic v_s4_o,
    output logic v_s5_o,
    output logic first_s2_o,                    // keep xD of this tile
    output logic first_s5_o,                    // restart group sum
    output logic last_s5_o                      // emit y
);

    ssm_ctrl_pkg::grp_phase_e              phase_r;
    logic [ssm_ctrl_pkg::TILE_CNT_W-1:0]   cnt_r;     // tiles seen in current group
    logic                                  first_w;
    logic                                  last_w;
    logic [ssm_ctrl_pkg::LAT_PIPE-1:0]     v_pipe;    // bit k = stage k+1
    logic [ssm_ctrl_pkg::LAT_PIPE-1:0]     first_pipe;
    logic [ssm_ctrl_pkg::LAT_PIPE-1:0]     last_pipe;

    // ========================================
    // group tracking
    // ========================================
    assign first_w = tile_valid_i && (phase_r == ssm_ctrl_pkg::GRP_FIRST);
    assign last_w  = tile_valid_i && (cnt_r == ssm_cfg_pkg::TILES_PER_GROUP - 1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase_r <= ssm_ctrl_pkg::GRP_FIRST;
            cnt_r   <= '0;
        end else if (tile_valid_i) begin    // gaps just hold the count
            if (last_w) begin
                phase_r <= ssm_ctrl_pkg::GRP_FIRST;
                cnt_r   <= '0;
            end else begin
                phase_r <= ssm_ctrl_pkg::GRP_MID;
                cnt_r   <= cnt_r + 1'b1;
            end
        end
    end

    // ========================================
    // valid / flag pipeline
    // ========================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            v_pipe     <= '0;
            first_pipe <= '0;
            last_pipe  <= '0;
        end else begin
            v_pipe     <= {v_pipe[ssm_ctrl_pkg::LAT_PIPE-2:0], tile_valid_i};
            first_pipe <= {first_pipe[ssm_ctrl_pkg::LAT_PIPE-2:0], first_w};
            last_pipe  <= {last_pipe[ssm_ctrl_pkg::LAT_PIPE-2:0], last_w};
        end
    end

    assign v_s1_o     = v_pipe[0];
    assign v_s2_o     = v_pipe[1];
    assign v_s3_o     = v_pipe[2];
    assign v_s4_o     = v_pipe[3];
    assign v_s5_o     = v_pipe[4];
    assign first_s2_o = first_pipe[ssm_ctrl_pkg::LAT_XD_KEEP-1];
    assign first_s5_o = first_pipe[ssm_ctrl_pkg::LAT_PIPE-1];
    assign last_s5_o  = last_pipe[ssm_ctrl_pkg::LAT_PIPE-1];

    // flags never travel without their tile
    a_first_s2_valid: assert property (@(posedge clk) disable iff (!rstn)
        first_s2_o |-> v_s2_o);
    a_flags_s5_valid: assert property (@(posedge clk) disable iff (!rstn)
        (first_s5_o || last_s5_o) |-> v_s5_o);

    a_cnt_range: assert property (@(posedge clk) disable iff (!rstn)
        cnt_r < ssm_cfg_pkg::TILES_PER_GROUP);

endmodule

`default_nettype wire

//--- ssm_ctrl_pkg.sv
// ssm control definitions
`default_nettype none

package ssm_ctrl_pkg;

    // ========================================
    // group phase
    // ========================================
    typedef enum logic {
        GRP_FIRST,                              // next accepted tile opens a group
        GRP_MID                                 // inside a group
    } grp_phase_e;

    // ========================================
    // stage latencies
    // ========================================
    localparam int LAT_SCALAR = 2;              // delta, then dx / xD
    localparam int LAT_STATE  = 1;              // hnext
    localparam int LAT_REDUCE = 2;              // tile sum, then group sum
    localparam int LAT_PIPE   = LAT_SCALAR + LAT_STATE + LAT_REDUCE;

    // xD is latched at the end of the scalar stage
    localparam int LAT_XD_KEEP = LAT_SCALAR;

    // counts 0 .. TILES_PER_GROUP-1, one spare bit so overrun is visible
    localparam int TILE_CNT_W = $clog2(ssm_cfg_pkg::TILES_PER_GROUP + 1);

endpackage

`default_nettype wire

//--- ssm_cfg_pkg.sv
// ssm datapath configuration
// sizes, q8.8 format and lane types
`default_nettype none

package ssm_cfg_pkg;

    // ========================================
    // sizes
    // ========================================
    localparam int DATA_W  = 16;                // one q8.8 value
    localparam int FRAC_W  = 8;                 // fraction bits
    localparam int N_TILE  = 4;                 // state lanes per tile
    localparam int N_TOTAL = 16;                // state lanes per group
    localparam int TILES_PER_GROUP = (N_TOTAL + N_TILE - 1) / N_TILE;  // ceil

    // ========================================
    // types
    // ========================================
    typedef logic signed [DATA_W-1:0] lane_t;   // single signed value
    typedef lane_t [N_TILE-1:0] tile_vec_t;     // B, C, hprev, hnext

    // fixed-point multiply
    // full signed product, arithmetic shift by FRAC_W, keep low DATA_W bits
    function automatic lane_t qmul(input lane_t a, input lane_t b);
        logic signed [2*DATA_W-1:0] prod;
        logic signed [2*DATA_W-1:0] prod_sh;
        prod    = a * b;
        prod_sh = prod >>> FRAC_W;
        return prod_sh[DATA_W-1:0];             // wraps, no saturation
    endfunction

endpackage

`default_nettype wire
